// ==== codec_conditioner.sv ====
module codec_conditioner (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mix_ready,
    input  midi_pkg::sample_t mix_sample,
    input  logic              new_frame,
    output logic              generate_next,
    output midi_pkg::sample_t sample_out
);

    import midi_pkg::*;

    sample_t held_sample;  // latest mix, waiting for the next codec frame.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_sample   <= '0;  // the first frame after reset plays silence.
            generate_next <= 1'b0;
            sample_out    <= '0;
        end else begin
            generate_next <= new_frame;  // asks the voices for the next sample.
            if (mix_ready) begin
                held_sample <= mix_sample;
            end
            if (new_frame) begin
                sample_out <= held_sample;  // one frame behind the request.
            end
        end
    end

    // the mix answers a request several cycles later, never in the same cycle.
    a_mix_not_on_request: assert property (
        @(posedge clk) disable iff (!rst_n) !(mix_ready && generate_next)
    );

endmodule

// ==== compile.f ====
+incdir+.
midi_pkg.sv
midi_msg_capture.sv
midi_msg_handler.sv
midi_note.sv
polyphony_mixer.sv
codec_conditioner.sv
midi_player.sv
midi_player_tb.sv

// ==== midi_msg_capture.sv ====
module midi_msg_capture (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 byte_valid,
    input  midi_pkg::midi_byte_t byte_in,
    output logic                 new_msg,
    output midi_pkg::midi_msg_t  msg
);

    import midi_pkg::*;

    midi_byte_t status_q;     // last status byte seen.
    midi_byte_t data1_q;      // first data byte of the message in progress.
    logic       have_status;  // a status byte opened the current message.
    logic       have_data1;   // the first data byte is already stored.

    // control part of the framer.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_status <= 1'b0;
            have_data1  <= 1'b0;
            new_msg     <= 1'b0;
        end else begin
            new_msg <= 1'b0;  // the message strobe lasts a single cycle.
            if (byte_valid) begin
                if (byte_in[7]) begin
                    have_status <= 1'b1;  // a status byte always restarts framing.
                    have_data1  <= 1'b0;
                end else if (have_status) begin
                    if (!have_data1) begin
                        have_data1 <= 1'b1;
                    end else begin
                        new_msg     <= 1'b1;  // the second data byte completes the message.
                        have_data1  <= 1'b0;
                        have_status <= 1'b0;  // running status is not supported.
                    end
                end
            end
        end
    end

    // payload part of the framer.
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (byte_in[7]) begin
                status_q <= byte_in;
            end else if (have_status && !have_data1) begin
                data1_q <= byte_in;
            end else if (have_status) begin
                msg <= '{status: status_q, data1: data1_q, data2: byte_in};
            end
        end
    end

    // a message needs three strobes, so two messages can never be back to back.
    a_new_msg_single: assert property (
        @(posedge clk) disable iff (!rst_n) new_msg |=> !new_msg
    );

endmodule

// ==== midi_msg_handler.sv ====
`include "synth_settings.svh"

module midi_msg_handler (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         new_msg,
    input  midi_pkg::midi_msg_t                          msg,
    input  midi_pkg::voice_mask_t                        voice_busy,
    output midi_pkg::voice_setting_t [`NUM_VOICES-1:0]   voice_settings,
    output midi_pkg::voice_mask_t                        update_voice,
    output midi_pkg::voice_mask_t                        release_voice,
    output midi_pkg::volume_t                            volume
);

    import midi_pkg::*;

    handler_state_t state;      // where the handler is in its three cycle sequence.
    midi_msg_t      msg_q;      // message under decode.
    midi_data_t     key;        // key or controller number of the message.
    midi_data_t     vel;        // velocity or controller value of the message.
    logic           note_on;    // note-on with a velocity above zero.
    logic           note_off;   // note-off, or note-on with zero velocity.
    logic           vol_ctl;    // the controller message that sets the volume.
    voice_mask_t    free_pick;  // lowest voice that is not busy.
    voice_mask_t    key_hits;   // busy voices that hold the key of the message.

    assign key = msg_q.data1[6:0];
    assign vel = msg_q.data2[6:0];

    assign note_on  = (msg_q.status[7:4] == 4'h9) && (vel != '0);
    assign note_off = (msg_q.status[7:4] == 4'h8) ||
                      ((msg_q.status[7:4] == 4'h9) && (vel == '0));
    assign vol_ctl  = (msg_q.status[7:4] == 4'hB) &&
                      (msg_q.data1 == midi_byte_t'(`VOLUME_CC));

    // isolates the lowest set bit of the free mask.
    assign free_pick = ~voice_busy & voice_mask_t'(voice_busy + 1'b1);

    always_comb begin
        for (int i = 0; i < `NUM_VOICES; i++) begin
            key_hits[i] = voice_busy[i] && (voice_settings[i].key == key);
        end
    end

    always_ff @(posedge clk) begin
        if (new_msg) begin
            msg_q <= msg;  // omni mode, so the channel nibble is never looked at.
        end
    end

    // voice table, written only for a voice that is about to be loaded.
    always_ff @(posedge clk) begin
        if (state == hs_decode && note_on) begin
            for (int i = 0; i < `NUM_VOICES; i++) begin
                if (free_pick[i]) begin
                    voice_settings[i] <= '{key: key, velocity: vel};
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= hs_idle;
            update_voice  <= '0;
            release_voice <= '0;
            volume        <= volume_t'(`DEFAULT_VOLUME);
        end else begin
            update_voice  <= '0;  // both strobes last one cycle.
            release_voice <= '0;
            case (state)
                hs_idle: begin
                    if (new_msg) begin
                        state <= hs_decode;
                    end
                end
                hs_decode: begin
                    if (note_on) begin
                        update_voice <= free_pick;  // all zero when no voice is free.
                    end
                    if (note_off) begin
                        release_voice <= key_hits;
                    end
                    if (vol_ctl) begin
                        volume <= {vel, 1'b0};  // value 64 gives unity gain.
                    end
                    state <= hs_write;
                end
                hs_write: begin
                    state <= hs_idle;  // voices act on the strobes in this cycle.
                end
                default: begin
                    state <= hs_idle;
                end
            endcase
        end
    end

    // a load goes to exactly one voice, and that voice was idle.
    a_update_free_one_hot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(update_voice) && ((update_voice & voice_busy) == '0)
    );

endmodule

// ==== midi_note.sv ====
`include "synth_settings.svh"

module midi_note (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     update_voice,
    input  logic                     release_voice,
    input  midi_pkg::voice_setting_t setting,
    input  logic                     generate_next,
    output logic                     busy,
    output logic                     sample_ready,
    output midi_pkg::sample_t        sample
);

    import midi_pkg::*;

    logic [7:0] half_period;  // frames between two polarity flips.
    logic [7:0] frame_count;  // frames spent at the current polarity.
    logic       positive;     // current level of the square wave.
    sample_t    magnitude;    // amplitude taken from the velocity.

    // key 0 gives the longest period and key 127 a flip on every frame.
    assign half_period = 8'(`PERIOD_BASE) - {1'b0, setting.key};

    // velocity shifted left by eight, which keeps the top bit clear.
    assign magnitude = sample_t'({1'b0, setting.velocity, 8'h00});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            frame_count  <= '0;
            positive     <= 1'b1;
            sample_ready <= 1'b0;
            sample       <= '0;
        end else begin
            sample_ready <= generate_next;  // all voices step together.
            if (generate_next) begin
                if (busy) begin
                    sample <= positive ? magnitude : -magnitude;
                end else begin
                    sample <= '0;  // an idle voice adds nothing to the mix.
                end
                if (frame_count == half_period - 8'd1) begin
                    frame_count <= '0;
                    positive    <= ~positive;
                end else begin
                    frame_count <= frame_count + 8'd1;
                end
            end
            if (update_voice) begin
                busy        <= 1'b1;  // a load wins over a frame step.
                frame_count <= '0;
                positive    <= 1'b1;
            end else if (release_voice) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// ==== midi_pkg.sv ====
`include "synth_settings.svh"

package midi_pkg;

    typedef logic [7:0]                 midi_byte_t;   // one raw byte from the serial port.
    typedef logic [6:0]                 midi_data_t;   // a data value such as a key or velocity.
    typedef logic signed [15:0]         sample_t;      // one signed audio sample.
    typedef logic [7:0]                 volume_t;      // master volume where 128 is unity.
    typedef logic [`NUM_VOICES-1:0]     voice_mask_t;  // one bit for each voice.

    // a complete three byte message as it leaves the capture block.
    typedef struct packed {
        midi_byte_t status;  // status byte with bit 7 set.
        midi_byte_t data1;   // key or controller number.
        midi_byte_t data2;   // velocity or controller value.
    } midi_msg_t;

    // the settings that one voice plays from.
    typedef struct packed {
        midi_data_t key;       // sets the pitch of the square wave.
        midi_data_t velocity;  // sets the amplitude of the square wave.
    } voice_setting_t;

    // states of the message handler.
    typedef enum logic [1:0] {
        hs_idle,    // waits for the next message.
        hs_decode,  // works out which voices the message touches.
        hs_write    // the strobes to the voices are out in this state.
    } handler_state_t;

endpackage

// ==== midi_player.sv ====
`include "synth_settings.svh"

module midi_player (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  new_frame,
    input  logic                  byte_valid,
    input  midi_pkg::midi_byte_t  byte_in,
    output midi_pkg::sample_t     sample_out,
    output logic                  new_sample_generated,
    output midi_pkg::voice_mask_t playing
);

    import midi_pkg::*;

    logic                              new_msg;         // a full message is ready.
    midi_msg_t                         msg;             // the message itself.
    voice_setting_t [`NUM_VOICES-1:0]  voice_settings;  // voice table entries.
    voice_mask_t                       update_voice;    // load strobes to the voices.
    voice_mask_t                       release_voice;   // release strobes to the voices.
    voice_mask_t                       voice_ready;     // sample strobes from the voices.
    volume_t                           volume;          // master volume.
    sample_t [`NUM_VOICES-1:0]         voice_samples;   // one sample per voice.
    logic                              mix_ready;       // the mixed sample is ready.
    sample_t                           mix_sample;      // the mixed sample.

    midi_msg_capture u_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_in    (byte_in),
        .new_msg    (new_msg),
        .msg        (msg)
    );

    midi_msg_handler u_handler (
        .clk            (clk),
        .rst_n          (rst_n),
        .new_msg        (new_msg),
        .msg            (msg),
        .voice_busy     (playing),
        .voice_settings (voice_settings),
        .update_voice   (update_voice),
        .release_voice  (release_voice),
        .volume         (volume)
    );

    for (genvar i = 0; i < `NUM_VOICES; i++) begin : g_voice
        midi_note u_note (
            .clk           (clk),
            .rst_n         (rst_n),
            .update_voice  (update_voice[i]),
            .release_voice (release_voice[i]),
            .setting       (voice_settings[i]),
            .generate_next (new_sample_generated),
            .busy          (playing[i]),
            .sample_ready  (voice_ready[i]),
            .sample        (voice_samples[i])
        );
    end

    // every voice steps on the same pulse, so voice 0 speaks for all of them.
    polyphony_mixer u_mixer (
        .clk           (clk),
        .rst_n         (rst_n),
        .samples_ready (voice_ready[0]),
        .samples       (voice_samples),
        .volume        (volume),
        .mix_ready     (mix_ready),
        .mix_sample    (mix_sample)
    );

    codec_conditioner u_conditioner (
        .clk           (clk),
        .rst_n         (rst_n),
        .mix_ready     (mix_ready),
        .mix_sample    (mix_sample),
        .new_frame     (new_frame),
        .generate_next (new_sample_generated),
        .sample_out    (sample_out)
    );

endmodule

// ==== midi_player_tb.sv ====
`include "synth_settings.svh"

module midi_player_tb;

    import midi_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        new_frame;
    logic        byte_valid;
    midi_byte_t  byte_in;
    sample_t     sample_out;
    logic        new_sample_generated;
    voice_mask_t playing;

    int          errors;                   // checks that failed so far.
    int          checks;                   // checks done so far.
    sample_t     samples[$];               // sample_out of each frame in the last run.
    int          chord_key[`NUM_VOICES];   // model of the voice table, keys.
    int          chord_vel[`NUM_VOICES];   // model of the voice table, velocities.
    voice_mask_t chord_mask;               // voices the model expects to be busy.
    int          chord_vol;                // volume the model expects.

    midi_player u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .new_frame            (new_frame),
        .byte_valid           (byte_valid),
        .byte_in              (byte_in),
        .sample_out           (sample_out),
        .new_sample_generated (new_sample_generated),
        .playing              (playing)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // period of 100 units.
    end

    // every task leaves the time at 10 units after a rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst_n      = 1'b0;
        new_frame  = 1'b0;
        byte_valid = 1'b0;
        repeat (4) next_cycle();  // reset stays low for four cycles.
        rst_n      = 1'b1;
        chord_mask = '0;  // all voices are free after reset.
        chord_vol  = `DEFAULT_VOLUME;
        next_cycle();
    endtask

    task automatic send_byte(input midi_byte_t value);
        byte_valid = 1'b1;
        byte_in    = value;
        next_cycle();
        byte_valid = 1'b0;  // a one cycle strobe with a gap behind it.
        next_cycle();
    endtask

    // a note takes effect four cycles after the strobe of its last byte.
    task automatic send_msg(input midi_byte_t status, input midi_byte_t data1,
                            input midi_byte_t data2);
        send_byte(status);
        send_byte(data1);
        send_byte(data2);
        repeat (4) next_cycle();
    endtask

    // sends a note-on and puts it in the lowest free slot of the model.
    task automatic start_note(input int key, input int vel);
        int slot;
        slot = -1;
        for (int i = `NUM_VOICES - 1; i >= 0; i--) begin
            if (!chord_mask[i]) begin
                slot = i;
            end
        end
        send_msg(8'h90, 8'(key), 8'(vel));
        if (slot >= 0) begin  // with no free slot the note is dropped.
            chord_mask[slot] = 1'b1;
            chord_key[slot]  = key;
            chord_vel[slot]  = vel;
        end
    endtask

    task automatic run_frames(input int count);
        int wait_cycles;
        samples.delete();
        repeat (count) begin
            new_frame = 1'b1;
            next_cycle();
            new_frame   = 1'b0;
            wait_cycles = 0;
            while (!new_sample_generated && wait_cycles < 20) begin
                next_cycle();
                wait_cycles++;
            end
            if (!new_sample_generated) begin
                errors++;
                $display("timeout: new_sample_generated did not follow new_frame");
            end
            samples.push_back(sample_out);
            next_cycle();
            check_value("new_sample_generated", new_sample_generated, 0);  // a one cycle pulse.
            repeat (7) next_cycle();  // keeps frames nine cycles apart.
        end
    endtask

    // mix of the model voices at a step counted from their common load.
    function automatic int expected_mix(input int step);
        int sum;
        int half;
        int scaled;
        sum = 0;
        for (int i = 0; i < `NUM_VOICES; i++) begin
            if (chord_mask[i]) begin
                half = `PERIOD_BASE - chord_key[i];
                sum += ((step / half) % 2 == 0) ? chord_vel[i] * 256 : -chord_vel[i] * 256;
            end
        end
        scaled = (sum * chord_vol) >>> 7;  // 128 is unity gain.
        if (scaled > 32767) begin
            scaled = 32767;
        end else if (scaled < -32768) begin
            scaled = -32768;
        end
        return scaled;
    endfunction

    // frame zero still plays the mix from before the run, so it is skipped.
    task automatic compare_with_model(input int count);
        run_frames(count);
        for (int j = 1; j < samples.size(); j++) begin
            check_value("sample_out", samples[j], expected_mix(j - 1));
        end
    endtask

    task automatic idle_after_reset();
        apply_reset();
        check_value("playing", playing, 0);
        check_value("new_sample_generated", new_sample_generated, 0);
        run_frames(3);
        foreach (samples[j]) begin
            check_value("sample_out", samples[j], 0);
        end
    endtask

    task automatic play_single_note();
        int key;
        int vel;
        int half;
        int run;
        int sign_changes;
        logic last_neg;
        apply_reset();
        key  = 100 + $urandom_range(26, 0);
        vel  = 1 + $urandom_range(126, 0);
        half = `PERIOD_BASE - key;
        start_note(key, vel);
        check_value("playing", playing, 1);
        run_frames(3 * half + 2);
        run          = 0;
        sign_changes = 0;
        last_neg     = samples[1] < 0;
        for (int j = 1; j < samples.size(); j++) begin
            check_value("sample magnitude", (samples[j] < 0) ? -samples[j] : samples[j],
                        vel << 8);
            if ((samples[j] < 0) != last_neg) begin
                if (sign_changes > 0) begin
                    check_value("run length", run, half);  // the run just closed is whole.
                end
                sign_changes++;
                run      = 0;
                last_neg = samples[j] < 0;
            end
            run++;
        end
        check_value("sign changes seen", sign_changes >= 2, 1);
    endtask

    task automatic fill_all_voices();
        int base;
        apply_reset();
        base = 100 + $urandom_range(5, 0);
        for (int i = 0; i < 5; i++) begin
            start_note(base + 5 * i, 1 + $urandom_range(126, 0));  // the fifth is dropped.
        end
        check_value("playing", playing, 4'b1111);
        compare_with_model(40);
    endtask

    // runs on the four voices that fill_all_voices left playing.
    task automatic release_and_reuse();
        send_msg(8'h80, 8'(chord_key[1]), 8'h00);
        chord_mask[1] = 1'b0;
        check_value("playing", playing, 4'b1101);
        send_msg(8'h90, 8'(chord_key[2]), 8'h00);  // zero velocity acts as a note-off.
        chord_mask[2] = 1'b0;
        check_value("playing", playing, 4'b1001);
        start_note(90, 64);
        check_value("playing", playing, 4'b1011);  // voice 1 is the lowest free one.
    endtask

    task automatic scale_volume();
        apply_reset();
        start_note(110 + $urandom_range(10, 0), 1 + $urandom_range(126, 0));
        send_msg(8'hB0, 8'(`VOLUME_CC), 8'd32);
        chord_vol = 64;  // twice the controller value, so half of unity.
        compare_with_model(30);
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            start_note(124, 127);  // same key, so all four voices stay in phase.
        end
        send_msg(8'hB0, 8'(`VOLUME_CC), 8'd127);
        chord_vol = 254;
        compare_with_model(12);
        check_value("sample_out", samples[1], 32'h0000_7FFF);
        check_value("sample_out", samples[5], 32'hFFFF_8000);
    endtask

    task automatic restart_framing();
        send_byte(8'h90);  // a note-on status that the reset below cuts off.
        apply_reset();
        send_byte(8'h40);  // data bytes with no status before them.
        send_byte(8'h23);
        repeat (4) next_cycle();
        check_value("playing", playing, 0);
        send_byte(8'h90);
        send_byte(8'h33);  // this message is cut short by the next status byte.
        start_note(115, 100);
        send_byte(8'h11);  // no running status, so these two bytes are dropped.
        send_byte(8'h22);
        repeat (4) next_cycle();
        check_value("playing", playing, 1);
        send_msg(8'h80, 8'd115, 8'h00);  // the voice holds the key of the second message.
        check_value("playing", playing, 0);
    endtask

    initial begin
        rst_n      = 1'b0;
        new_frame  = 1'b0;
        byte_valid = 1'b0;
        byte_in    = '0;
        errors     = 0;
        checks     = 0;
        void'($urandom(24340));
        idle_after_reset();
        play_single_note();
        fill_all_voices();
        release_and_reuse();
        scale_volume();
        restart_framing();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== polyphony_mixer.sv ====
`include "synth_settings.svh"

module polyphony_mixer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  samples_ready,
    input  midi_pkg::sample_t [`NUM_VOICES-1:0]   samples,
    input  midi_pkg::volume_t                     volume,
    output logic                                  mix_ready,
    output midi_pkg::sample_t                     mix_sample
);

    import midi_pkg::*;

    localparam int SUM_W  = 16 + $clog2(`NUM_VOICES);  // the sum of all voices never overflows.
    localparam int PROD_W = SUM_W + 9;                  // the volume enters as a signed 9 bit value.
    localparam int SCL_W  = PROD_W - 7;                 // width after the divide by 128.

    logic signed [SUM_W-1:0]  sum_d;      // combinational sum of the voices.
    logic signed [SUM_W-1:0]  sum_q;      // registered sum.
    logic                     sum_valid;  // the registered sum is new.
    logic signed [PROD_W-1:0] product;    // sum times volume.
    logic signed [SCL_W-1:0]  scaled;     // product divided by 128.
    logic [SCL_W-16:0]        upper;      // sign bit and the bits above it.
    sample_t                  clipped;    // scaled value held to the 16 bit range.

    always_comb begin
        sum_d = '0;
        for (int i = 0; i < `NUM_VOICES; i++) begin
            sum_d = sum_d + SUM_W'(samples[i]);  // the cast extends the sign.
        end
    end

    assign product = sum_q * $signed({1'b0, volume});
    assign scaled  = product[PROD_W-1:7];
    assign upper   = scaled[SCL_W-1:15];

    // the value fits when all upper bits agree with the sign.
    assign clipped = ((upper == '0) || (upper == '1)) ? scaled[15:0] :
                     scaled[SCL_W-1] ? 16'sh8000 : 16'sh7FFF;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid  <= 1'b0;
            sum_q      <= '0;
            mix_ready  <= 1'b0;
            mix_sample <= '0;
        end else begin
            sum_valid <= samples_ready;
            mix_ready <= sum_valid;  // two cycles after the voices report.
            if (samples_ready) begin
                sum_q <= sum_d;
            end
            if (sum_valid) begin
                mix_sample <= clipped;  // volume is sampled in this second stage.
            end
        end
    end

endmodule

// ==== synth_settings.svh ====
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// voice pool and pitch settings.
`define NUM_VOICES     4    // number of voices in the pool, eight also works.
`define PERIOD_BASE    128  // half period in frames is this value minus the key.

// master volume settings.
`define DEFAULT_VOLUME 128  // multiplier after reset, which is unity gain.
`define VOLUME_CC      7    // controller number that sets the master volume.

`endif
